//--- fsab_pkg.sv
//////////////////////////////
// FSAB bus definitions shared by the data cache and the memory target.
// Import with fsab_pkg::* in the module header.
//////////////////////////////

package fsab_pkg;

	// request mode carried on fsabo_mode
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	// device and sub-device ids, echoed back on read beats
	typedef logic [3:0] fsab_did_t;
	typedef logic [3:0] fsab_subdid_t;

	localparam fsab_did_t    FSAB_DID_CPU           = 4'h0;
	localparam fsab_subdid_t FSAB_SUBDID_CPU_DCACHE = 4'h1;

	// bus field widths
	localparam int FSAB_ADDR_W = 31; // byte address
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;  // one bit per byte lane
	localparam int FSAB_LEN_W  = 4;  // beats per request

	// outstanding request credits, up to 7
	typedef logic [2:0] fsab_credit_t;

endpackage

//--- dcache_pkg.sv
//////////////////////////////
// Data cache geometry and address decode types.
// Import with dcache_pkg::* where the cache layout is needed.
//////////////////////////////

package dcache_pkg;

	localparam int DC_LINES      = 16;
	localparam int DC_LINE_WORDS = 8; // 64-bit words per line

	localparam int DC_TAG_W  = 22;
	localparam int DC_IDX_W  = 4;
	localparam int DC_OFF_W  = 6;
	localparam int DC_WORD_W = $clog2(DC_LINE_WORDS);

	// field view of a core address
	typedef struct packed {
		logic [DC_TAG_W-1:0]  tag;
		logic [DC_IDX_W-1:0]  idx;
		logic [DC_WORD_W-1:0] word;
		logic                 half;     // picks hi or lo 32 bits
		logic [1:0]           byte_off;
	} dc_addr_fields_t;

	// raw word for bus addresses, fields for lookup
	typedef union packed {
		logic [31:0]     raw;
		dc_addr_fields_t f;
	} dc_addr_u;

	// {line, word} into the data arrays
	typedef logic [DC_IDX_W+DC_WORD_W-1:0] dc_ram_addr_t;

endpackage

//--- dcache_line_ram.sv
//////////////////////////////
// Cache data arrays, split into high and low 32-bit halves.
// Async read for zero-wait hits, one shared write port.
//////////////////////////////

`timescale 1ns/100ps

module dcache_line_ram
	import dcache_pkg::*;
(
	input  logic         clk,

	// read port, combinational
	input  dc_ram_addr_t raddr,
	output logic [31:0]  rdata_hi,
	output logic [31:0]  rdata_lo,

	// write port, fills use both halves
	input  dc_ram_addr_t waddr,
	input  logic         we_hi,
	input  logic         we_lo,
	input  logic [31:0]  wdata_hi,
	input  logic [31:0]  wdata_lo
);

	localparam int RAM_DEPTH = DC_LINES * DC_LINE_WORDS;

	logic [31:0] ram_hi [RAM_DEPTH];
	logic [31:0] ram_lo [RAM_DEPTH];

	// upper word of each 64-bit beat
	always_ff @(posedge clk) begin
		if (we_hi)
			ram_hi[waddr] <= wdata_hi;
	end

	// lower word
	always_ff @(posedge clk) begin
		if (we_lo)
			ram_lo[waddr] <= wdata_lo;
	end

	assign rdata_hi = ram_hi[raddr];
	assign rdata_lo = ram_lo[raddr];

endmodule

//--- dcache.sv
//////////////////////////////
// Direct-mapped write-through data cache with an FSAB master port.
// Core side uses rd_req/wr_req with a combinational rw_wait stall.
//////////////////////////////

`timescale 1ns/100ps

module dcache
	import fsab_pkg::*;
	import dcache_pkg::*;
#(
	parameter int FSAB_CREDITS = 4
) (
	input  logic                   clk,
	input  logic                   reset,

	// core port
	input  logic [31:0]            addr,
	input  logic                   rd_req,
	input  logic                   wr_req,
	input  logic [31:0]            wr_data,
	output logic                   rw_wait,
	output logic [31:0]            rd_data,

	// outbound bus
	output logic                   fsabo_valid,
	output fsab_mode_t             fsabo_mode,
	output fsab_did_t              fsabo_did,
	output fsab_subdid_t           fsabo_subdid,
	output logic [FSAB_ADDR_W-1:0] fsabo_addr,
	output logic [FSAB_LEN_W-1:0]  fsabo_len,
	output logic [FSAB_DATA_W-1:0] fsabo_data,
	output logic [FSAB_MASK_W-1:0] fsabo_mask,
	input  logic                   fsabo_credit,

	// inbound bus
	input  logic                   fsabi_valid,
	input  fsab_did_t              fsabi_did,
	input  fsab_subdid_t           fsabi_subdid,
	input  logic [FSAB_DATA_W-1:0] fsabi_data
);

	dc_addr_u a;
	dc_addr_u fill_a; // line being fetched

	logic [DC_TAG_W-1:0] tags [DC_LINES];
	logic [DC_LINES-1:0] valid;

	fsab_credit_t credits;
	logic credit_avail;

	logic cache_hit;
	logic start_read;
	logic store_hit;
	logic fill_beat;
	logic read_pending;
	logic [DC_WORD_W-1:0] fill_pos;

	dc_ram_addr_t ram_waddr;
	logic ram_we_hi, ram_we_lo;
	logic [31:0] ram_wdata_hi, ram_wdata_lo;
	logic [31:0] ram_rdata_hi, ram_rdata_lo;

	assign a.raw = addr;

	assign credit_avail = (credits != '0);
	assign cache_hit = valid[a.f.idx] && (tags[a.f.idx] == a.f.tag);

	assign rw_wait = (rd_req && !cache_hit) || (wr_req && !credit_avail);
	assign rd_data = a.f.half ? ram_rdata_hi : ram_rdata_lo;

	assign start_read = rd_req && !cache_hit && !read_pending && credit_avail;
	assign store_hit = wr_req && cache_hit && credit_avail;
	assign fill_beat = fsabi_valid && (fsabi_did == FSAB_DID_CPU) &&
		(fsabi_subdid == FSAB_SUBDID_CPU_DCACHE);

	// one-cycle requests where a line read wins over a write
	always_comb begin
		fsabo_valid  = 1'b0;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = FSAB_DID_CPU;
		fsabo_subdid = FSAB_SUBDID_CPU_DCACHE;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		fsabo_data   = '0;
		fsabo_mask   = '0;
		if (start_read) begin
			fsabo_valid = 1'b1;
			fsabo_addr  = {a.raw[FSAB_ADDR_W-1:DC_OFF_W], {DC_OFF_W{1'b0}}}; // line aligned
			fsabo_len   = FSAB_LEN_W'(DC_LINE_WORDS);
		end else if (wr_req && credit_avail) begin
			fsabo_valid = 1'b1;
			fsabo_mode  = FSAB_WRITE;
			fsabo_addr  = {a.raw[FSAB_ADDR_W-1:3], 3'b000};
			fsabo_len   = FSAB_LEN_W'(1);
			fsabo_data  = {wr_data, wr_data}; // mask picks the half
			fsabo_mask  = a.f.half ? 8'hF0 : 8'h0F;
		end
	end

	// returned minus sent
	always_ff @(posedge clk) begin
		if (reset)
			credits <= fsab_credit_t'(FSAB_CREDITS);
		else
			credits <= credits + fsab_credit_t'(fsabo_credit) - fsab_credit_t'(fsabo_valid);
	end

	// fill sequencing and line valid bits
	always_ff @(posedge clk) begin
		if (reset) begin
			read_pending <= 1'b0;
			fill_pos     <= '0;
			valid        <= '0;
		end else if (start_read) begin
			read_pending     <= 1'b1;
			fill_pos         <= '0;
			valid[a.f.idx]   <= 1'b0; // old contents get overwritten
		end else if (fill_beat) begin
			fill_pos <= fill_pos + 1'b1;
			if (fill_pos == DC_WORD_W'(DC_LINE_WORDS - 1)) begin
				valid[fill_a.f.idx] <= 1'b1;
				read_pending        <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_read)
			fill_a.raw <= a.raw;
		if (fill_beat && fill_pos == DC_WORD_W'(DC_LINE_WORDS - 1))
			tags[fill_a.f.idx] <= fill_a.f.tag;
	end

	// fill beats and store hits share the write port
	// the core is stalled during a fill, so they never collide
	always_comb begin
		if (fill_beat) begin
			ram_waddr    = {fill_a.f.idx, fill_pos};
			ram_we_hi    = 1'b1;
			ram_we_lo    = 1'b1;
			ram_wdata_hi = fsabi_data[63:32];
			ram_wdata_lo = fsabi_data[31:0];
		end else begin
			ram_waddr    = {a.f.idx, a.f.word};
			ram_we_hi    = store_hit && a.f.half;
			ram_we_lo    = store_hit && !a.f.half;
			ram_wdata_hi = wr_data;
			ram_wdata_lo = wr_data;
		end
	end

	dcache_line_ram u_line_ram (
		.clk      (clk),
		.raddr    ({a.f.idx, a.f.word}),
		.rdata_hi (ram_rdata_hi),
		.rdata_lo (ram_rdata_lo),
		.waddr    (ram_waddr),
		.we_hi    (ram_we_hi),
		.we_lo    (ram_we_lo),
		.wdata_hi (ram_wdata_hi),
		.wdata_lo (ram_wdata_lo)
	);

	// beats only arrive for an outstanding line read
	a_beat_needs_fill: assert property (
		@(posedge clk) disable iff (reset) fill_beat |-> read_pending
	);

	// target must not hand back more credits than it owns
	a_credit_bound: assert property (
		@(posedge clk) disable iff (reset) credits <= fsab_credit_t'(FSAB_CREDITS)
	);

endmodule

//--- fsab_mem.sv
//////////////////////////////
// FSAB memory target with an in-order request queue.
// Queue depth matches the credit count, one credit per retire.
//////////////////////////////

`timescale 1ns/100ps

module fsab_mem
	import fsab_pkg::*;
#(
	parameter int FSAB_CREDITS = 4,
	parameter int MEM_ADDR_W   = 10 // log2 of 64-bit words
) (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   fsabo_valid,
	input  fsab_mode_t             fsabo_mode,
	input  fsab_did_t              fsabo_did,
	input  fsab_subdid_t           fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,
	output logic                   fsabo_credit,

	output logic                   fsabi_valid,
	output fsab_did_t              fsabi_did,
	output fsab_subdid_t           fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data
);

	localparam int PTR_W = (FSAB_CREDITS > 1) ? $clog2(FSAB_CREDITS) : 1;

	// request queue
	fsab_mode_t             q_mode   [FSAB_CREDITS];
	fsab_did_t              q_did    [FSAB_CREDITS];
	fsab_subdid_t           q_subdid [FSAB_CREDITS];
	logic [FSAB_ADDR_W-1:0] q_addr   [FSAB_CREDITS];
	logic [FSAB_LEN_W-1:0]  q_len    [FSAB_CREDITS];
	logic [FSAB_DATA_W-1:0] q_data   [FSAB_CREDITS];
	logic [FSAB_MASK_W-1:0] q_mask   [FSAB_CREDITS];

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	fsab_credit_t count;

	logic [FSAB_DATA_W-1:0] mem [2**MEM_ADDR_W];

	logic [FSAB_LEN_W-1:0] beat; // beats sent for the head read
	logic [MEM_ADDR_W-1:0] head_word;
	logic head_valid, head_wr, head_rd, last_beat, pop;

	assign head_valid = (count != '0);
	assign head_wr    = head_valid && (q_mode[rd_ptr] == FSAB_WRITE);
	assign head_rd    = head_valid && (q_mode[rd_ptr] == FSAB_READ);
	assign last_beat  = (beat == q_len[rd_ptr] - 1'b1);
	assign pop        = head_wr || (head_rd && last_beat);
	assign head_word  = q_addr[rd_ptr][MEM_ADDR_W+2:3]; // 64-bit aligned

	// capture into the tail
	always_ff @(posedge clk) begin
		if (fsabo_valid) begin
			q_mode[wr_ptr]   <= fsabo_mode;
			q_did[wr_ptr]    <= fsabo_did;
			q_subdid[wr_ptr] <= fsabo_subdid;
			q_addr[wr_ptr]   <= fsabo_addr;
			q_len[wr_ptr]    <= fsabo_len;
			q_data[wr_ptr]   <= fsabo_data;
			q_mask[wr_ptr]   <= fsabo_mask;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			beat         <= '0;
			fsabi_valid  <= 1'b0;
			fsabo_credit <= 1'b0;
		end else begin
			if (fsabo_valid)
				wr_ptr <= (wr_ptr == PTR_W'(FSAB_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FSAB_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + fsab_credit_t'(fsabo_valid) - fsab_credit_t'(pop);

			fsabi_valid  <= head_rd;
			fsabo_credit <= pop; // credit leaves with the retire
			if (head_rd)
				beat <= last_beat ? '0 : beat + 1'b1;
		end
	end

	// word array and read beat data
	always_ff @(posedge clk) begin
		if (head_wr) begin
			for (int b = 0; b < FSAB_MASK_W; b++) begin
				if (q_mask[rd_ptr][b])
					mem[head_word][b*8 +: 8] <= q_data[rd_ptr][b*8 +: 8];
			end
		end
		fsabi_data   <= mem[head_word + MEM_ADDR_W'(beat)];
		fsabi_did    <= q_did[rd_ptr];
		fsabi_subdid <= q_subdid[rd_ptr];
	end

	// master must wait for a credit
	a_no_overflow: assert property (
		@(posedge clk) disable iff (reset)
		fsabo_valid |-> (count < fsab_credit_t'(FSAB_CREDITS))
	);

endmodule

//--- dcache_subsys.sv
//////////////////////////////
// Data cache joined to an FSAB memory target.
// Exposes the core port only.
//////////////////////////////

`timescale 1ns/100ps

module dcache_subsys
	import fsab_pkg::*;
#(
	parameter int FSAB_CREDITS = 4,
	parameter int MEM_ADDR_W   = 10
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] addr,
	input  logic        rd_req,
	input  logic        wr_req,
	input  logic [31:0] wr_data,
	output logic        rw_wait,
	output logic [31:0] rd_data
);

	logic                   fsabo_valid;
	fsab_mode_t             fsabo_mode;
	fsab_did_t              fsabo_did;
	fsab_subdid_t           fsabo_subdid;
	logic [FSAB_ADDR_W-1:0] fsabo_addr;
	logic [FSAB_LEN_W-1:0]  fsabo_len;
	logic [FSAB_DATA_W-1:0] fsabo_data;
	logic [FSAB_MASK_W-1:0] fsabo_mask;
	logic                   fsabo_credit;

	logic                   fsabi_valid;
	fsab_did_t              fsabi_did;
	fsab_subdid_t           fsabi_subdid;
	logic [FSAB_DATA_W-1:0] fsabi_data;

	dcache #(
		.FSAB_CREDITS (FSAB_CREDITS)
	) u_dcache (
		.clk          (clk),
		.reset        (reset),
		.addr         (addr),
		.rd_req       (rd_req),
		.wr_req       (wr_req),
		.wr_data      (wr_data),
		.rw_wait      (rw_wait),
		.rd_data      (rd_data),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	fsab_mem #(
		.FSAB_CREDITS (FSAB_CREDITS),
		.MEM_ADDR_W   (MEM_ADDR_W)
	) u_mem (
		.clk          (clk),
		.reset        (reset),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

endmodule

//--- tb_dcache_subsys.sv
//////////////////////////////
// Directed testbench for the data cache subsystem.
// Checks reads against a shadow of every written word.
//////////////////////////////

`timescale 1ns/100ps

module tb_dcache_subsys;

	localparam int FSAB_CREDITS = 2;
	localparam int MEM_ADDR_W   = 10;
	localparam int TIMEOUT      = 200; // cycles per request

	logic        clk;
	logic        reset;
	logic [31:0] addr;
	logic        rd_req;
	logic        wr_req;
	logic [31:0] wr_data;
	logic        rw_wait;
	logic [31:0] rd_data;

	logic [31:0] shadow [2048]; // 32-bit words below 0x2000
	integer seed;
	int errors;
	int checks;
	int tests;

	dcache_subsys #(
		.FSAB_CREDITS (FSAB_CREDITS),
		.MEM_ADDR_W   (MEM_ADDR_W)
	) dut0 (
		.clk     (clk),
		.reset   (reset),
		.addr    (addr),
		.rd_req  (rd_req),
		.wr_req  (wr_req),
		.wr_data (wr_data),
		.rw_wait (rw_wait),
		.rd_data (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
			input logic [31:0] a);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: rd_data = %h, expected %h (addr %h)", $time, got, exp, a);
		end
	endtask

	task automatic check_wait(input logic got, input logic exp, input logic [31:0] a);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: rw_wait = %b, expected %b (addr %h)", $time, got, exp, a);
		end
	endtask

	// entered on a falling edge, returns on one with the request dropped
	task automatic do_write(input logic [31:0] a, input logic [31:0] d);
		int n;
		addr    = a;
		wr_data = d;
		wr_req  = 1'b1;
		rd_req  = 1'b0;
		#1;
		n = 0;
		while (rw_wait && n < TIMEOUT) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (rw_wait) begin
			$display("timeout: write to %h still stalled after %0d cycles", a, n);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			shadow[a[12:2]] = d;
			@(negedge clk);
			wr_req = 1'b0;
		end
	endtask

	task automatic do_read(input logic [31:0] a, output logic [31:0] data,
			output logic first_wait);
		int n;
		addr   = a;
		rd_req = 1'b1;
		wr_req = 1'b0;
		#1;
		first_wait = rw_wait; // stall seen in the request cycle
		n = 0;
		while (rw_wait && n < TIMEOUT) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (rw_wait) begin
			$display("timeout: read of %h still stalled after %0d cycles", a, n);
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			data = rd_data;
			@(negedge clk);
			rd_req = 1'b0;
		end
	endtask

	task automatic read_and_compare(input logic [31:0] a, input bit chk_wait,
			input logic exp_wait);
		logic [31:0] data;
		logic first_wait;
		do_read(a, data, first_wait);
		check_data(data, shadow[a[12:2]], a);
		if (chk_wait)
			check_wait(first_wait, exp_wait, a);
	endtask

	task automatic test_write_read_miss();
		addr    = 32'h0000_0100;
		wr_data = 32'hA5A5_0100;
		wr_req  = 1'b1;
		#1;
		check_wait(rw_wait, 1'b0, addr); // full credit count after reset
		do_write(32'h0000_0100, 32'hA5A5_0100);
		do_write(32'h0000_0104, 32'h1234_5678);
		do_write(32'h0000_0110, 32'hDEAD_BEEF);
		do_write(32'h0000_013C, 32'h0BAD_F00D);
		read_and_compare(32'h0000_0110, 1'b1, 1'b1);
	endtask

	task automatic test_read_hit();
		read_and_compare(32'h0000_0100, 1'b1, 1'b0);
		read_and_compare(32'h0000_013C, 1'b1, 1'b0);
		read_and_compare(32'h0000_0104, 1'b1, 1'b0);
	endtask

	task automatic test_store_hit();
		do_write(32'h0000_0110, 32'hCAFE_0110);
		read_and_compare(32'h0000_0110, 1'b1, 1'b0);
		// both halves of one 64-bit word
		do_write(32'h0000_0108, 32'h1111_0108);
		do_write(32'h0000_010C, 32'h2222_010C);
		read_and_compare(32'h0000_0108, 1'b1, 1'b0);
		read_and_compare(32'h0000_010C, 1'b1, 1'b0);
	endtask

	task automatic test_conflict();
		do_write(32'h0000_0048, 32'h0048_AAAA); // index 1 with tag 0
		do_write(32'h0000_0448, 32'h0448_BBBB); // tag 1
		for (int i = 0; i < 2; i++) begin
			read_and_compare(32'h0000_0048, 1'b1, 1'b1);
			read_and_compare(32'h0000_0448, 1'b1, 1'b1);
		end
	endtask

	task automatic test_credit_backpressure();
		for (int i = 0; i < 2 * FSAB_CREDITS; i++)
			do_write(32'h0000_0200 + 32'(i * 4), $random(seed));
		for (int i = 0; i < 2 * FSAB_CREDITS; i++)
			read_and_compare(32'h0000_0200 + 32'(i * 4), 1'b1, i == 0);
	endtask

	task automatic test_random_mix();
		logic [31:0] written [$];
		logic [31:0] a;
		int pick;
		for (int i = 0; i < 150; i++) begin
			if (written.size() == 0 || ($random(seed) & 1)) begin
				a = 32'h0000_1000 + (($random(seed) & 32'h1FF) << 2); // tags 4 and 5
				do_write(a, $random(seed));
				written.push_back(a);
			end else begin
				pick = {$random(seed)} % written.size();
				read_and_compare(written[pick], 1'b0, 1'b0);
			end
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests++;
		if (errors == err0)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - err0);
	endtask

	initial begin
		int err0;
		seed    = 86;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		reset   = 1'b1;
		addr    = '0;
		rd_req  = 1'b0;
		wr_req  = 1'b0;
		wr_data = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		err0 = errors;
		test_write_read_miss();
		report_test("write then read miss", err0);
		err0 = errors;
		test_read_hit();
		report_test("read hit", err0);
		err0 = errors;
		test_store_hit();
		report_test("store hit update", err0);
		err0 = errors;
		test_conflict();
		report_test("conflict eviction", err0);
		err0 = errors;
		test_credit_backpressure();
		report_test("credit back-pressure", err0);
		err0 = errors;
		test_random_mix();
		report_test("random mix", err0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- all.f
fsab_pkg.sv
dcache_pkg.sv
dcache_line_ram.sv
dcache.sv
fsab_mem.sv
dcache_subsys.sv
tb_dcache_subsys.sv

//--- Bender.yml
package:
  name: dcache_subsys

sources:
  - fsab_pkg.sv
  - dcache_pkg.sv
  - dcache_line_ram.sv
  - dcache.sv
  - fsab_mem.sv
  - dcache_subsys.sv
  - target: test
    files:
      - tb_dcache_subsys.sv
